//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal -j 0
TOP      = obj_tb
FILELIST = verilog.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		echo "simulation did not pass"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/obj_assertions.sv
// handshake checks on scanner, draw engine and ROM port, bound into the sprite top level
module obj_assertions (
    input logic        clk,
    input logic        rst,
    input logic        dr_start,
    input logic        dr_busy,
    input logic [19:0] rom_addr,
    input logic        rom_req,
    input logic        rom_ack
);

// commands only go to an idle draw engine
a_start_idle: assert property (@(posedge clk) disable iff (rst) dr_start |-> !dr_busy)
    else $error("dr_start raised while dr_busy high");

a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    rom_req && $past(rom_req) |-> $stable(rom_addr))
    else $error("rom_addr changed during a request");

a_req_hold: assert property (@(posedge clk) disable iff (rst) $fell(rom_req) |-> $past(rom_ack))
    else $error("rom_req dropped before rom_ack");

// four-phase, wait for ack low before the next request
a_req_rise: assert property (@(posedge clk) disable iff (rst) $rose(rom_req) |-> !rom_ack)
    else $error("rom_req raised while rom_ack high");

endmodule

bind obj_top obj_assertions u_assert (
    .clk(clk), .rst(rst), .dr_start(dr_start), .dr_busy(dr_busy),
    .rom_addr(rom_addr), .rom_req(rom_req), .rom_ack(rom_ack)
);

//--- bench/obj_tb.sv
// random-stimulus testbench for the sprite engine, checks every played-back line against a model
module obj_tb;

localparam int     OBJ_WORDS   = 4;
localparam int     LINE_CYC    = 512;
localparam int     SWEEP       = 320;                           // hdump 0 to 319
localparam int     TEST_LINES  = 20 + 24 + 20 + 16 + 28 + 16;
localparam int     TOTAL_LINES = TEST_LINES + 6;                // one flush line per test
localparam longint TIMEOUT     = longint'(TOTAL_LINES * LINE_CYC + 8000) * 8;

logic                       clk = 1'b0;
logic                       rst;
logic [obj_pkg::TBL_AW-1:0] cpu_addr;
logic [15:0]                cpu_din;
logic                       cpu_we;
logic                       flip;
logic                       hstart;
logic [8:0]                 vrender;
logic [8:0]                 hdump;
logic [19:0]                rom_addr;
logic                       rom_req;
logic                       rom_ack;
logic [15:0]                rom_data;
obj_pkg::obj_pxl_t          obj_pxl;

logic [31:0]       seed     = 32'hc811_27d4;
logic [31:0]       rom_seed = 32'hc811_27d4;  // separate stream for the ROM delays
int                lat_max  = 4;
int                errors   = 0;
int                fails    = 0;
int                tests    = 0;
logic [15:0]       tbl [1024];                 // model copy of table and scratch words
obj_pkg::obj_pxl_t exp_line [512];             // what the next hstart plays back

obj_top #(.OBJ_WORDS(OBJ_WORDS)) dut_i (.*);

always #4 clk = ~clk;

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic int unsigned rnd(input int unsigned n);
    seed = lcg_step(seed);
    return (seed >> 8) % n;
endfunction

// fixed scramble of the whole ROM address
function automatic logic [15:0] rom_word(input logic [19:0] a);
    logic [31:0] h;
    h = {12'd0, a} * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    return h[15:0] ^ h[31:16];
endfunction

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        errors++;
        $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

// graphics ROM, four-phase with a random answer delay
initial begin
    int lat;
    rom_ack  = 1'b0;
    rom_data = '0;
    forever begin
        @(posedge clk);
        if (rom_req && !rom_ack) begin
            rom_seed = lcg_step(rom_seed);
            lat      = 1 + int'((rom_seed >> 8) % lat_max);
            repeat (lat - 1) @(posedge clk);
            rom_ack  <= 1'b1;
            rom_data <= rom_word(rom_addr);
            do @(posedge clk); while (rom_req);
            rom_ack <= 1'b0;
        end
    end
end

task automatic write_word(input int addr, input logic [15:0] data);
    @(posedge clk);
    cpu_addr  <= addr[obj_pkg::TBL_AW-1:0];
    cpu_din   <= data;
    cpu_we    <= 1'b1;
    tbl[addr]  = data;
endtask

// sprite line as the rules give it, also advances the scratch copies
task automatic model_line(input logic [8:0] vr, input logic f);
    logic [8:0]  vrf;
    logic [7:0]  top;
    logic [7:0]  bot;
    logic [15:0] off;
    logic [15:0] attr;
    logic [15:0] word;
    logic [3:0]  color;
    logic [8:0]  col;
    logic        stop;
    int          sel;
    vrf  = f ? 9'd223 - vr : vr;
    stop = 1'b0;
    for (int c = 0; c < 512; c++) exp_line[c] = '0;
    for (int i = 0; i < 128 && !stop && vrf < 9'd224; i++) begin
        top = tbl[i * 8][7:0];
        bot = tbl[i * 8][15:8];
        if (bot >= 8'hf0) begin
            stop = 1'b1;  // end of table
        end else if (top < bot && vrf[7:0] >= top && vrf[7:0] < bot) begin
            off  = (vrf[7:0] == top ? tbl[i * 8 + 3] : tbl[i * 8 + 7]) + tbl[i * 8 + 2];
            attr = tbl[i * 8 + 4];
            tbl[i * 8 + 7] = off;
            for (int p = 0; p < 4 * OBJ_WORDS; p++) begin
                sel   = off[15] ? OBJ_WORDS - 1 - p / 4 : p / 4;
                word  = rom_word({1'b0, attr[6:4], 16'({1'b0, off[14:0]} + 16'(sel))});
                color = off[15] ? word[4 * (p % 4) +: 4] : word[15 - 4 * (p % 4) -: 4];
                col   = tbl[i * 8 + 1][8:0] + 9'(p);
                if (color != 4'd0) exp_line[col] = {attr[1:0], attr[13:8], color};
            end
        end
    end
endtask

// one 512-cycle line: start it, check the playback of the previous line, model this one
task automatic run_line(input int line, input logic f);
    logic [8:0] vr;
    vr = f ? 9'(223 - line) : 9'(line);
    @(negedge clk);
    if (dut_i.dr_busy) begin
        errors++;
        $display("draw engine still busy when line %0d started", line);
    end
    @(posedge clk);
    hstart  <= 1'b1;
    vrender <= vr;
    flip    <= f;
    for (int k = 0; k <= SWEEP; k++) begin
        @(posedge clk);
        hstart <= 1'b0;
        if (k < SWEEP) hdump <= 9'(k);
        @(negedge clk);
        if (k > 0) check_val($sformatf("obj_pxl[%0d]", k - 1), obj_pxl, exp_line[k - 1]);
    end
    model_line(vr, f);
    repeat (LINE_CYC - SWEEP - 2) @(posedge clk);
endtask

task automatic run_test(input string name, input int n, input int em, input int base,
                        input int nlines, input logic f, input int xlo, input int xspan,
                        input bit hflip_ok, input int lat);
    int         err0;
    logic [7:0] top;
    logic [7:0] bot;
    err0    = errors;
    lat_max = lat;
    for (int i = 0; i <= n; i++) begin
        top = 8'(base + rnd(nlines));
        bot = (rnd(5) == 0) ? top - 8'(rnd(4)) : top + 8'(1 + rnd(12));  // some bad objects
        if (i == em || i == n) bot = 8'hf0 + 8'(rnd(16));
        write_word(i * 8, {bot, top});
        write_word(i * 8 + 1, 16'(xlo + rnd(xspan)));
        write_word(i * 8 + 2, 16'(rnd(65536)));                          // signed pitch
        write_word(i * 8 + 3, {1'(hflip_ok ? rnd(2) : 0), 15'(rnd(32768))});
        write_word(i * 8 + 4, 16'(rnd(65536)));
        write_word(i * 8 + 7, 16'(rnd(65536)));
    end
    @(posedge clk);
    cpu_we <= 1'b0;
    for (int l = 0; l < nlines; l++) run_line(base + l, f);
    run_line(300, 1'b0);  // empty line, plays back the last drawn one
    tests++;
    if (errors != err0) fails++;
    $display("%-14s %0d lines, %0d errors", name, nlines, errors - err0);
endtask

initial begin
    #(TIMEOUT);
    $display("watchdog expired, the tests did not finish in time");
    $display("Testbench failed");
    $finish;
end

initial begin
    rst      = 1'b1;
    cpu_addr = '0;
    cpu_din  = '0;
    cpu_we   = 1'b0;
    flip     = 1'b0;
    hstart   = 1'b0;
    vrender  = '0;
    hdump    = '0;
    for (int c = 0; c < 512; c++) exp_line[c] = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (520) @(posedge clk);  // line buffer power-up sweep
    run_test("zone",      8, 8,  20, 20, 1'b0, 0,   512, 1'b0, 4);
    run_test("pitch",     6, 6,  40, 24, 1'b0, 0,   512, 1'b0, 4);
    run_test("flip",      6, 6,  60, 20, 1'b1, 0,   512, 1'b1, 4);
    run_test("priority",  8, 8,  90, 16, 1'b0, 100, 8,   1'b1, 4);
    run_test("end mark",  8, 3, 200, 28, 1'b0, 0,   512, 1'b1, 4);
    run_test("rom stall", 5, 5, 130, 16, 1'b1, 0,   512, 1'b1, 12);
    $display("%0d tests, %0d failed, %0d errors", tests, fails, errors);
    if (errors == 0) begin
        $display("Testbench passed");
    end else begin
        $display("Testbench failed");
    end
    $finish;
end

endmodule

//--- design/obj_draw.sv
// fetches one sprite line from graphics ROM and turns it into line buffer pixel writes
module obj_draw #(
    parameter int OBJ_WORDS = 4  // sprite width in ROM words, 4 pixels each
) (
    input  logic                  clk,
    input  logic                  rst,
    // scanner
    input  logic                  dr_start,
    input  obj_pkg::draw_cmd_t    dr_cmd,
    output logic                  dr_busy,
    // graphics ROM, four-phase
    output logic [19:0]           rom_addr,
    output logic                  rom_req,
    input  logic                  rom_ack,
    input  logic [15:0]           rom_data,
    // line buffer
    output obj_pkg::lb_write_t    lb_wr
);

localparam int WCW = $clog2(OBJ_WORDS + 1);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,  // req high, waiting for ack
    ST_REL,  // req low, waiting for ack to drop
    ST_PIX   // four pixels out
} state_t;

state_t             st;
logic [WCW-1:0]     wcnt;
logic [1:0]         nib;
obj_pkg::draw_cmd_t cmd;
logic [15:0]        pxl_word;
logic [8:0]         col;
logic               hflip;
logic [15:0]        word_sel;
logic [15:0]        word_addr;
logic [3:0]         color;

assign hflip     = cmd.offset[15];
assign word_sel  = hflip ? 16'(OBJ_WORDS - 1) - 16'(wcnt) : 16'(wcnt);  // flip walks right to left
assign word_addr = {1'b0, cmd.offset[14:0]} + word_sel;
assign rom_addr  = {cmd.bank, word_addr};
assign rom_req   = st == ST_REQ;
assign dr_busy   = st != ST_IDLE;

// high nibble first, low nibble first when flipped
assign color = hflip ? pxl_word[3:0] : pxl_word[15:12];

always_comb begin
    lb_wr.addr      = col;
    lb_wr.pxl.prio  = cmd.prio;
    lb_wr.pxl.pal   = cmd.pal;
    lb_wr.pxl.color = color;
    lb_wr.we        = st == ST_PIX && color != 4'd0;
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        st   <= ST_IDLE;
        wcnt <= '0;
        nib  <= '0;
    end else begin
        case (st)
            ST_IDLE: begin
                if (dr_start) begin
                    wcnt <= '0;
                    st   <= ST_REQ;
                end
            end
            ST_REQ: if (rom_ack) st <= ST_REL;
            ST_REL: begin
                if (!rom_ack) begin
                    nib <= '0;
                    st  <= ST_PIX;
                end
            end
            ST_PIX: begin
                nib <= nib + 2'd1;
                if (nib == 2'd3) begin
                    if (wcnt == WCW'(OBJ_WORDS - 1)) begin
                        st <= ST_IDLE;
                    end else begin
                        wcnt <= wcnt + 1'd1;
                        st   <= ST_REQ;
                    end
                end
            end
            default: st <= ST_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (st == ST_IDLE && dr_start) begin
        cmd <= dr_cmd;
        col <= dr_cmd.xpos;
    end
    if (st == ST_REQ && rom_ack) begin
        pxl_word <= rom_data;
    end
    if (st == ST_PIX) begin
        col      <= col + 9'd1;  // wraps at 512
        pxl_word <= hflip ? pxl_word >> 4 : pxl_word << 4;
    end
end

endmodule

//--- design/obj_line_buf.sv
// two-half line buffer, one half takes sprite pixels while the other plays back and clears
module obj_line_buf (
    input  logic               clk,
    input  logic               rst,
    input  logic               hstart,
    input  obj_pkg::lb_write_t lb_wr,
    input  logic [8:0]         hdump,
    output obj_pkg::obj_pxl_t  obj_pxl
);

logic       bank;      // half being drawn
logic       play_q;    // half that fed the last read
logic       clearing;  // power-up sweep of both halves
logic [8:0] sweep;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        bank     <= 1'b0;
        play_q   <= 1'b1;
        clearing <= 1'b1;
        sweep    <= '0;
    end else begin
        play_q <= ~bank;
        if (hstart) begin
            bank <= ~bank;
        end
        if (clearing) begin
            sweep <= sweep + 9'd1;
            if (&sweep) clearing <= 1'b0;
        end
    end
end

for (genvar h = 0; h < 2; h++) begin : g_half
    obj_pkg::obj_pxl_t mem [512];
    obj_pkg::obj_pxl_t rd_q;
    obj_pkg::obj_pxl_t wr_data;
    logic [8:0]        wr_addr;
    logic              wr_en;

    // one write port: sweep, sprite write or read-clear
    always_comb begin
        if (clearing) begin
            wr_en   = 1'b1;
            wr_addr = sweep;
            wr_data = '0;
        end else if (bank == 1'(h)) begin
            wr_en   = lb_wr.we;
            wr_addr = lb_wr.addr;
            wr_data = lb_wr.pxl;
        end else begin
            wr_en   = 1'b1;
            wr_addr = hdump;
            wr_data = '0;  // leave it transparent for the next draw
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_q <= clearing ? '0 : mem[hdump];
    end
end

assign obj_pxl = play_q ? g_half[1].rd_q : g_half[0].rd_q;

endmodule

//--- design/obj_pkg.sv
// types and constants shared by the sprite engine blocks, referenced as obj_pkg::name
package obj_pkg;

localparam int         VISIBLE_LINES = 224;
localparam logic [7:0] END_MARK      = 8'hf0;  // bottom at or above this ends the table
localparam logic [2:0] SCRATCH_IDX   = 3'd7;   // per-object running offset
localparam int         TBL_AW        = 10;     // 128 objects x 8 words

// scanner to draw engine
typedef struct packed {
    logic [ 8:0] xpos;    // left column
    logic [15:0] offset;  // graphics word offset, bit 15 is h flip
    logic [ 3:0] bank;
    logic [ 1:0] prio;
    logic [ 5:0] pal;
} draw_cmd_t;

// one line buffer entry, color 0 is transparent
typedef struct packed {
    logic [1:0] prio;
    logic [5:0] pal;
    logic [3:0] color;
} obj_pxl_t;

// draw engine to line buffer
typedef struct packed {
    logic [8:0] addr;
    obj_pxl_t   pxl;
    logic       we;
} lb_write_t;

endpackage

//--- design/obj_scan.sv
// walks the object table once per visible line and sends a draw command for every object in zone
module obj_scan (
    input  logic                       clk,
    input  logic                       rst,
    // video timing
    input  logic                       flip,
    input  logic                       hstart,
    input  logic [8:0]                 vrender,
    // object table
    output logic [obj_pkg::TBL_AW-1:0] tbl_addr,
    output logic [15:0]                tbl_din,
    output logic                       tbl_we,
    input  logic [15:0]                tbl_dout,
    // draw engine
    output logic                       dr_start,
    input  logic                       dr_busy,
    output obj_pkg::draw_cmd_t         dr_cmd
);

typedef enum logic [2:0] {
    ST_IDLE,
    ST_ZONE,     // word 0 on tbl_dout
    ST_XPOS,     // word 1
    ST_PITCH,    // word 2
    ST_OFFS,     // word 3
    ST_ATTR,     // word 4
    ST_SCRATCH,  // word 7
    ST_DRAW
} state_t;

state_t      st;
logic [6:0]  cur_obj;
logic [2:0]  idx;
logic        pending;  // address just moved to a new object, data not back yet
logic        start;
logic        last_obj;

// per object data
logic [7:0]  vline;
logic        first;
logic [8:0]  xpos;
logic [15:0] pitch;    // signed, plain add wraps the same way
logic [15:0] offset;
logic [3:0]  bank;
logic [1:0]  prio;
logic [5:0]  pal;

logic [8:0]  vrf;
logic [7:0]  top;
logic [7:0]  bottom;
logic        inzone;
logic        badobj;
logic        endmark;
logic [15:0] next_offset;

assign vrf      = flip ? 9'd223 - vrender : vrender;
assign start    = st == ST_IDLE && hstart && vrf < 9'(obj_pkg::VISIBLE_LINES);
assign last_obj = &cur_obj;

assign top     = tbl_dout[7:0];
assign bottom  = tbl_dout[15:8];
assign inzone  = vline >= top && vline < bottom;
assign badobj  = top >= bottom;
assign endmark = bottom >= obj_pkg::END_MARK;

// top line starts from word 3, later lines from the scratch word
assign next_offset = (first ? offset : tbl_dout) + pitch;

assign tbl_addr = {cur_obj, idx};
assign tbl_din  = offset;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        st       <= ST_IDLE;
        cur_obj  <= '0;
        idx      <= '0;
        pending  <= 1'b0;
        tbl_we   <= 1'b0;
        dr_start <= 1'b0;
    end else begin
        tbl_we   <= 1'b0;
        dr_start <= 1'b0;
        case (st)
            ST_IDLE: begin
                cur_obj <= '0;
                idx     <= '0;  // word 0 of object 0 stays on the bus
                pending <= 1'b0;
                if (start) begin
                    idx <= 3'd1;
                    st  <= ST_ZONE;
                end
            end
            ST_ZONE: begin
                if (pending) begin
                    pending <= 1'b0;
                    idx     <= 3'd1;
                end else if (endmark) begin
                    st <= ST_IDLE;
                end else if (!inzone || badobj) begin
                    // skip without reading the rest of the entry
                    if (last_obj) begin
                        st <= ST_IDLE;
                    end else begin
                        cur_obj <= cur_obj + 7'd1;
                        idx     <= '0;
                        pending <= 1'b1;
                    end
                end else begin
                    idx <= 3'd2;
                    st  <= ST_XPOS;
                end
            end
            ST_XPOS: begin
                idx <= 3'd3;
                st  <= ST_PITCH;
            end
            ST_PITCH: begin
                idx <= 3'd4;
                st  <= ST_OFFS;
            end
            ST_OFFS: begin
                idx <= obj_pkg::SCRATCH_IDX;
                st  <= ST_ATTR;
            end
            ST_ATTR: st <= ST_SCRATCH;
            ST_SCRATCH: begin
                tbl_we <= 1'b1;  // lands during the first draw cycle
                st     <= ST_DRAW;
            end
            ST_DRAW: begin
                if (!dr_busy) begin
                    dr_start <= 1'b1;
                    if (last_obj) begin
                        st <= ST_IDLE;
                    end else begin
                        cur_obj <= cur_obj + 7'd1;
                        idx     <= '0;
                        pending <= 1'b1;
                        st      <= ST_ZONE;
                    end
                end
            end
            default: st <= ST_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (start) begin
        vline <= vrf[7:0];
    end
    case (st)
        ST_ZONE:    first  <= top == vline;
        ST_XPOS:    xpos   <= tbl_dout[8:0];
        ST_PITCH:   pitch  <= tbl_dout;
        ST_OFFS:    offset <= tbl_dout;
        ST_ATTR: begin
            pal  <= tbl_dout[13:8];
            bank <= {1'b0, tbl_dout[6:4]};
            prio <= tbl_dout[1:0];
        end
        ST_SCRATCH: offset <= next_offset;
        ST_DRAW: begin
            if (!dr_busy) begin
                dr_cmd.xpos   <= xpos;
                dr_cmd.offset <= offset;
                dr_cmd.bank   <= bank;
                dr_cmd.prio   <= prio;
                dr_cmd.pal    <= pal;
            end
        end
        default: ;
    endcase
end

endmodule

//--- design/obj_table_ram.sv
// object table memory, written by the CPU and read back and updated by the line scanner
module obj_table_ram (
    input  logic                       clk,
    // CPU side
    input  logic [obj_pkg::TBL_AW-1:0] cpu_addr,
    input  logic [15:0]                cpu_din,
    input  logic                       cpu_we,
    // scanner side
    input  logic [obj_pkg::TBL_AW-1:0] tbl_addr,
    input  logic [15:0]                tbl_din,
    input  logic                       tbl_we,
    output logic [15:0]                tbl_dout
);

localparam int DEPTH = 2 ** obj_pkg::TBL_AW;

logic [15:0] mem [DEPTH];

always_ff @(posedge clk) begin
    if (tbl_we) begin
        mem[tbl_addr] <= tbl_din;  // scratch write back
    end
    if (cpu_we) begin
        mem[cpu_addr] <= cpu_din;  // cpu wins if both hit one word
    end
    tbl_dout <= mem[tbl_addr];     // old data on a same-cycle write
end

endmodule

//--- design/obj_top.sv
// sprite engine top level, object table through scanner and draw engine into the line buffer
module obj_top #(
    parameter int OBJ_WORDS = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    // CPU table port
    input  logic [obj_pkg::TBL_AW-1:0] cpu_addr,
    input  logic [15:0]                cpu_din,
    input  logic                       cpu_we,
    // video timing
    input  logic                       flip,
    input  logic                       hstart,
    input  logic [8:0]                 vrender,
    input  logic [8:0]                 hdump,
    // graphics ROM
    output logic [19:0]                rom_addr,
    output logic                       rom_req,
    input  logic                       rom_ack,
    input  logic [15:0]                rom_data,
    output obj_pkg::obj_pxl_t          obj_pxl
);

logic [obj_pkg::TBL_AW-1:0] tbl_addr;
logic [15:0]                tbl_din;
logic [15:0]                tbl_dout;
logic                       tbl_we;
logic                       dr_start;
logic                       dr_busy;
obj_pkg::draw_cmd_t         dr_cmd;
obj_pkg::lb_write_t         lb_wr;

obj_table_ram u_tbl (
    .clk(clk), .cpu_addr(cpu_addr), .cpu_din(cpu_din), .cpu_we(cpu_we),
    .tbl_addr(tbl_addr), .tbl_din(tbl_din), .tbl_we(tbl_we), .tbl_dout(tbl_dout)
);

obj_scan u_scan (
    .clk(clk), .rst(rst), .flip(flip), .hstart(hstart), .vrender(vrender),
    .tbl_addr(tbl_addr), .tbl_din(tbl_din), .tbl_we(tbl_we), .tbl_dout(tbl_dout),
    .dr_start(dr_start), .dr_busy(dr_busy), .dr_cmd(dr_cmd)
);

obj_draw #(.OBJ_WORDS(OBJ_WORDS)) u_draw (
    .clk(clk), .rst(rst), .dr_start(dr_start), .dr_cmd(dr_cmd), .dr_busy(dr_busy),
    .rom_addr(rom_addr), .rom_req(rom_req), .rom_ack(rom_ack), .rom_data(rom_data),
    .lb_wr(lb_wr)
);

obj_line_buf u_lb (
    .clk(clk), .rst(rst), .hstart(hstart), .lb_wr(lb_wr), .hdump(hdump),
    .obj_pxl(obj_pxl)
);

endmodule

//--- verilog.f
design/obj_pkg.sv
design/obj_table_ram.sv
design/obj_scan.sv
design/obj_draw.sv
design/obj_line_buf.sv
design/obj_top.sv
bench/obj_assertions.sv
bench/obj_tb.sv
